/* source/load_return_consts.svh */
`ifndef LOAD_RETURN_CONSTS_SVH
`define LOAD_RETURN_CONSTS_SVH

// hardware threads sharing the load-return path
`define LR_NTHREADS 4

// architectural registers per thread, so a target is 5 bits
`define LR_NREGS 32

`define LR_XLEN 32         // data width of a memory word and a register

`define LR_FIFO_DEPTH 16   // response FIFO depth, keep it a power of two

`endif

/* source/load_return_pkg.sv */
`include "load_return_consts.svh"

package load_return_pkg;

   // ==========================================================
   // load size opcode
   // ==========================================================
   // the _u sizes zero-extend, the others sign-extend
   typedef enum logic [2:0] {
      load_byte   = 3'd0,
      load_byte_u = 3'd1,
      load_half   = 3'd2,
      load_half_u = 3'd3,
      load_word   = 3'd4
   } load_size_e;

   // ==========================================================
   // response and result records
   // ==========================================================
   // raw response as it comes back from memory
   typedef struct packed {
      logic [$clog2(`LR_NTHREADS)-1:0] thread;
      logic [$clog2(`LR_NREGS)-1:0]    tgt;     // destination register
      load_size_e                      size;
      logic [1:0]                      offset;  // byte position inside the word
      logic [`LR_XLEN-1:0]             data;    // whole word, not yet aligned
   } mem_resp_t;

   // aligned and extended value, ready for the register file
   typedef struct packed {
      logic [$clog2(`LR_NTHREADS)-1:0] thread;
      logic [$clog2(`LR_NREGS)-1:0]    tgt;
      logic [`LR_XLEN-1:0]             data;
   } load_result_t;

endpackage

/* source/load_capture.sv */
`include "load_return_consts.svh"

module load_capture (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           resp_valid,  // one strobe per response
   input  load_return_pkg::mem_resp_t     resp,
   output logic                           cap_valid,
   output load_return_pkg::load_result_t  cap_result
);
   import load_return_pkg::*;

   logic [7:0]          byte_sel;
   logic [15:0]         half_sel;
   logic [`LR_XLEN-1:0] ext_data;

   // ==========================================================
   // alignment, little-endian byte lanes
   // ==========================================================
   always_comb begin
      case (resp.offset)
         2'd0:    byte_sel = resp.data[7:0];
         2'd1:    byte_sel = resp.data[15:8];
         2'd2:    byte_sel = resp.data[23:16];
         default: byte_sel = resp.data[31:24];
      endcase
   end

   // a halfword only looks at offset bit 1, bit 0 is ignored
   assign half_sel = resp.offset[1] ? resp.data[31:16] : resp.data[15:0];

   // extension by size
   always_comb begin
      case (resp.size)
         load_byte:   ext_data = {{(`LR_XLEN-8){byte_sel[7]}}, byte_sel};
         load_byte_u: ext_data = {{(`LR_XLEN-8){1'b0}}, byte_sel};
         load_half:   ext_data = {{(`LR_XLEN-16){half_sel[15]}}, half_sel};
         load_half_u: ext_data = {{(`LR_XLEN-16){1'b0}}, half_sel};
         default:     ext_data = resp.data;  // full word passes straight through
      endcase
   end

   // ==========================================================
   // capture stage
   // ==========================================================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cap_valid <= 1'b0;
      end else begin
         cap_valid <= resp_valid;  // strobe delayed by exactly one cycle
      end
   end

   // payload only moves when a response is present
   always_ff @(posedge clk) begin
      if (resp_valid) begin
         cap_result.thread <= resp.thread;
         cap_result.tgt    <= resp.tgt;
         cap_result.data   <= ext_data;
      end
   end

endmodule

/* source/mem_resp_fifo.sv */
`include "load_return_consts.svh"

module mem_resp_fifo #(
   parameter int DEPTH = `LR_FIFO_DEPTH
) (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   wr,
   input  load_return_pkg::load_result_t          di,
   input  logic                                   pop,
   input  logic [`LR_NTHREADS-1:0]                rollback,
   output load_return_pkg::load_result_t          head,
   output logic                                   head_valid,
   output logic                                   head_live,
   output logic [$clog2(DEPTH+1)-1:0]             cnt,
   output logic                                   full,
   output logic                                   empty,
   output logic                                   overflow,
   output logic [`LR_NTHREADS-1:0][`LR_NREGS-1:0] pending
);
   import load_return_pkg::*;

   localparam int AW = $clog2(DEPTH);

   load_result_t mem [DEPTH];
   load_result_t rd_entry;                          // entry at the read pointer
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic          wr_ok;
   logic          pop_ok;
   logic [`LR_NTHREADS-1:0][`LR_NREGS-1:0] pend_nxt;

   assign full     = (cnt == DEPTH[$clog2(DEPTH+1)-1:0]);
   assign empty    = (cnt == '0);
   assign wr_ok    = wr & ~full;                    // a write into a full FIFO is dropped
   assign pop_ok   = pop & ~empty;
   assign rd_entry = mem[rd_ptr];

   // ==========================================================
   // storage and pointers
   // ==========================================================
   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= di;
      end
      if (pop_ok) begin
         head <= rd_entry;                          // registered read port
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         cnt        <= '0;
         overflow   <= 1'b0;
         head_valid <= 1'b0;
         head_live  <= 1'b0;
      end else begin
         if (wr_ok) wr_ptr <= wr_ptr + 1'b1;        // pointers wrap since DEPTH is 2**AW
         if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
         case ({wr_ok, pop_ok})
            2'b10:   cnt <= cnt + 1'b1;
            2'b01:   cnt <= cnt - 1'b1;
            default: cnt <= cnt;                    // both or neither leave the count alone
         endcase
         overflow   <= wr & full;                   // one-cycle pulse per lost write
         head_valid <= pop_ok;
         // the live bit is taken before this edge applies any clear
         head_live  <= pop_ok & pending[rd_entry.thread][rd_entry.tgt];
      end
   end

   // ==========================================================
   // pending-load bitmaps
   // ==========================================================
   // applied lowest priority first so later lines override earlier ones
   always_comb begin
      pend_nxt = pending;
      if (pop_ok) begin
         pend_nxt[rd_entry.thread][rd_entry.tgt] = 1'b0;
      end
      if (wr_ok) begin
         pend_nxt[di.thread][di.tgt] = 1'b1;        // a write beats a pop on the same bit
      end
      for (int t = 0; t < `LR_NTHREADS; t++) begin
         if (rollback[t]) begin
            pend_nxt[t] = '0;                       // rollback wipes the whole thread
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pending <= '0;
      end else begin
         pending <= pend_nxt;
      end
   end

endmodule

/* source/reg_writeback.sv */
`include "load_return_consts.svh"

module reg_writeback (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               empty,
   input  logic                               rf_busy,    // register-file port taken
   output logic                               pop,
   input  load_return_pkg::load_result_t      head,
   input  logic                               head_valid,
   input  logic                               head_live,
   output logic                               wb_valid,
   output load_return_pkg::load_result_t      wb_result,
   input  logic [$clog2(`LR_NTHREADS)-1:0]    rd_thread,
   input  logic [$clog2(`LR_NREGS)-1:0]       rd_reg,
   output logic [`LR_XLEN-1:0]                rd_data
);

   logic [`LR_XLEN-1:0] rf [`LR_NTHREADS][`LR_NREGS];
   logic [`LR_NTHREADS-1:0][`LR_NREGS-1:0] rf_vld;   // register written since reset
   logic wr_en;

   // ==========================================================
   // drain control
   // ==========================================================
   // empty is registered in the FIFO and already counts this pop, so
   // a single pending entry is never popped twice
   assign pop = ~empty & ~rf_busy;

   // a popped head always completes, even when rf_busy rises behind it,
   // so busy only holds back the next pop and nothing in flight is lost
   assign wr_en = head_valid & head_live;   // squashed heads just fall away

   // ==========================================================
   // register file write
   // ==========================================================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wb_valid <= 1'b0;
         rf_vld   <= '0;
      end else begin
         wb_valid <= wr_en;
         if (wr_en) begin
            rf_vld[head.thread][head.tgt] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         rf[head.thread][head.tgt] <= head.data;
         wb_result                 <= head;   // reported alongside wb_valid
      end
   end

   // read port for the rest of the core
   // an unwritten register reads zero until its first writeback
   assign rd_data = rf_vld[rd_thread][rd_reg] ? rf[rd_thread][rd_reg] : '0;

endmodule

/* source/load_return_top.sv */
`include "load_return_consts.svh"

module load_return_top (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   resp_valid,
   input  load_return_pkg::mem_resp_t             resp,
   input  logic [`LR_NTHREADS-1:0]                rollback,  // one bit per thread
   input  logic                                   rf_busy,
   output logic                                   wb_valid,
   output load_return_pkg::load_result_t          wb_result,
   input  logic [$clog2(`LR_NTHREADS)-1:0]        rd_thread,
   input  logic [$clog2(`LR_NREGS)-1:0]           rd_reg,
   output logic [`LR_XLEN-1:0]                    rd_data,
   output logic [$clog2(`LR_FIFO_DEPTH+1)-1:0]    cnt,
   output logic                                   full,
   output logic                                   empty,
   output logic                                   overflow,
   output logic [`LR_NTHREADS-1:0][`LR_NREGS-1:0] pending    // for hazard checks at issue
);
   import load_return_pkg::*;

   // ==========================================================
   // internal links
   // ==========================================================
   logic         cap_valid;
   load_result_t cap_result;   // extended value entering the FIFO
   logic         pop;
   load_result_t head;
   logic         head_valid;
   logic         head_live;

   // aligns and extends the raw response
   load_capture load_capture_i (
      .clk        (clk),
      .rst        (rst),
      .resp_valid (resp_valid),
      .resp       (resp),
      .cap_valid  (cap_valid),
      .cap_result (cap_result)
   );

   mem_resp_fifo #(
      .DEPTH (`LR_FIFO_DEPTH)
   ) mem_resp_fifo_i (
      .clk        (clk),
      .rst        (rst),
      .wr         (cap_valid),
      .di         (cap_result),
      .pop        (pop),
      .rollback   (rollback),
      .head       (head),
      .head_valid (head_valid),
      .head_live  (head_live),
      .cnt        (cnt),
      .full       (full),
      .empty      (empty),
      .overflow   (overflow),
      .pending    (pending)
   );

   // drains into the register file while its port is free
   reg_writeback reg_writeback_i (
      .clk        (clk),
      .rst        (rst),
      .empty      (empty),
      .rf_busy    (rf_busy),
      .pop        (pop),
      .head       (head),
      .head_valid (head_valid),
      .head_live  (head_live),
      .wb_valid   (wb_valid),
      .wb_result  (wb_result),
      .rd_thread  (rd_thread),
      .rd_reg     (rd_reg),
      .rd_data    (rd_data)
   );

endmodule

/* tests/load_return_tb.sv */
`include "load_return_consts.svh"

module load_return_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import load_return_pkg::*;

   // ==========================================================
   // run length
   // ==========================================================
   localparam int N_EXT   = 20;                      // 5 sizes by 4 offsets
   localparam int N_ORDER = 24;
   localparam int N_PEND  = 8;
   localparam int N_FULL  = `LR_FIFO_DEPTH + 2;      // two writes beyond full
   localparam int N_ROLL  = 8;
   localparam int LIMIT   = (N_EXT + N_ORDER + N_PEND + N_FULL + N_ROLL) * 8 + 200;

   logic                                   clk = 1'b0;
   logic                                   rst;
   logic                                   resp_valid;
   mem_resp_t                              resp;
   logic [`LR_NTHREADS-1:0]                rollback;
   logic                                   rf_busy;
   logic                                   wb_valid;
   load_result_t                           wb_result;
   logic [1:0]                             rd_thread;
   logic [4:0]                             rd_reg;
   logic [31:0]                            rd_data;
   logic [$clog2(`LR_FIFO_DEPTH+1)-1:0]    cnt;
   logic                                   full;
   logic                                   empty;
   logic                                   overflow;
   logic [`LR_NTHREADS-1:0][`LR_NREGS-1:0] pending;

   load_result_t exp_q [$];                          // live results in send order
   int           cyc_q [$];                          // send cycle of each live result
   logic [31:0]  exp_rf [`LR_NTHREADS][`LR_NREGS];   // register file as the model sees it
   int           cyc = 0;
   int           checks = 0;
   int           errors = 0;
   int           tests = 0;
   int           ovf_seen = 0;
   bit           check_latency = 1'b0;

   load_return_top load_return_top_i (.*);

   always #2 clk = ~clk;   // 4 ns period

   // cycle counter, stable at the falling edge where everything is sampled
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= LIMIT) begin
         $display("timeout after %0d cycles, the run stopped making progress", cyc);
         $display("Errors found");
         $finish;
      end
   end

   // writeback and overflow monitor
   always @(negedge clk) begin
      if (overflow) ovf_seen++;
      if (wb_valid) handle_writeback();
   end

   // ==========================================================
   // checking helpers and reference model
   // ==========================================================
   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] want);
      checks++;
      assert (got === want) else begin
         errors++;
         $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
      end
   endtask

   task automatic require(input bit ok, input string what);
      checks++;
      assert (ok) else begin
         errors++;
         $display("failure at %0t ns: %s", $time, what);
      end
   endtask

   // aligned and extended value as the load rules define it
   function automatic logic [31:0] extend_ref(input load_size_e size, input logic [1:0] offset,
                                              input logic [31:0] word);
      logic [31:0] by;
      logic [31:0] hw;
      by = word >> (8 * offset);        // byte lane moved to the bottom
      hw = word >> (16 * offset[1]);    // halfword lane follows offset bit 1 only
      case (size)
         load_byte:   extend_ref = 32'($signed(by[7:0]));
         load_byte_u: extend_ref = 32'(by[7:0]);
         load_half:   extend_ref = 32'($signed(hw[15:0]));
         load_half_u: extend_ref = 32'(hw[15:0]);
         default:     extend_ref = word;
      endcase
   endfunction

   task automatic handle_writeback();
      load_result_t want;
      int           sent;
      require(exp_q.size() != 0, "a writeback arrived with no live load outstanding");
      if (exp_q.size() != 0) begin
         want = exp_q.pop_front();
         sent = cyc_q.pop_front();
         compare_value("wb_result", 64'(wb_result), 64'(want));
         if (check_latency) compare_value("wb_valid latency", 64'(cyc - sent), 64'd4);
         exp_rf[want.thread][want.tgt] = want.data;   // model register file follows
      end
   endtask

   // one strobe per call, the next call or stop_resp ends it
   task automatic send_resp(input int th, input int tg, input load_size_e sz,
                            input logic [1:0] off, input logic [31:0] d, input bit live);
      load_result_t res;
      @(negedge clk);
      resp_valid = 1'b1;
      resp       = '{thread: 2'(th), tgt: 5'(tg), size: sz, offset: off, data: d};
      res        = '{thread: 2'(th), tgt: 5'(tg), data: extend_ref(sz, off, d)};
      if (live) begin
         exp_q.push_back(res);
         cyc_q.push_back(cyc);
      end
   endtask

   task automatic stop_resp();
      @(negedge clk);
      resp_valid = 1'b0;
   endtask

   task automatic wait_count(input int n);
      int t;
      t = 0;
      while (int'(cnt) != n && t < 100) begin
         @(negedge clk);
         t++;
      end
      require(int'(cnt) == n, $sformatf("the FIFO count never reached %0d", n));
   endtask

   task automatic drain_fifo();
      int t;
      t = 0;
      while ((exp_q.size() != 0 || !empty) && t < 200) begin
         @(negedge clk);
         t++;
      end
      require(exp_q.size() == 0, "expected writebacks never arrived");
      compare_value("empty", 64'(empty), 64'd1);
      repeat (3) @(negedge clk);   // a squashed head still needs its last two stages
   endtask

   task automatic read_back(input int th, input int tg);
      @(negedge clk);
      rd_thread = 2'(th);
      rd_reg    = 5'(tg);
      @(posedge clk);              // read port is combinational, settled by now
      compare_value($sformatf("rd_data[%0d][%0d]", th, tg), 64'(rd_data), 64'(exp_rf[th][tg]));
   endtask

   task automatic report_test(input string name, input int err0);
      tests++;
      $display("test %s done, %0d errors", name, errors - err0);
   endtask

   // ==========================================================
   // directed tests
   // ==========================================================
   task automatic extension_test();
      int err0;
      err0 = errors;
      check_latency = 1'b1;   // the path is idle before every strobe here
      for (int s = 0; s < 5; s++) begin
         for (int o = 0; o < 4; o++) begin
            send_resp(s % 4, s * 4 + o, load_size_e'(3'(s)), 2'(o), $urandom, 1'b1);
            stop_resp();
            drain_fifo();
         end
      end
      check_latency = 1'b0;
      report_test("extension", err0);
   endtask

   task automatic burst_order_test();
      int err0;
      int th_of [N_ORDER];
      err0 = errors;
      // distinct targets keep two loads off the same pending bit
      for (int i = 0; i < N_ORDER; i++) begin
         th_of[i] = int'($urandom % 4);
         send_resp(th_of[i], i, load_size_e'(3'($urandom % 5)), 2'($urandom), $urandom, 1'b1);
      end
      stop_resp();
      drain_fifo();
      for (int i = 0; i < N_ORDER; i++) read_back(th_of[i], i);
      report_test("burst order", err0);
   endtask

   task automatic pending_map_test();
      int          err0;
      logic [31:0] want [`LR_NTHREADS];
      err0 = errors;
      for (int t = 0; t < `LR_NTHREADS; t++) want[t] = '0;
      @(negedge clk);
      rf_busy = 1'b1;         // hold everything in the FIFO
      for (int i = 0; i < N_PEND; i++) begin
         send_resp(i % 4, 20 + i, load_word, 2'd0, $urandom, 1'b1);
         want[i % 4][20 + i] = 1'b1;
      end
      stop_resp();
      wait_count(N_PEND);
      for (int t = 0; t < `LR_NTHREADS; t++) begin
         compare_value($sformatf("pending[%0d]", t), 64'(pending[t]), 64'(want[t]));
      end
      @(negedge clk);
      rf_busy = 1'b0;
      drain_fifo();
      for (int t = 0; t < `LR_NTHREADS; t++) begin
         compare_value($sformatf("pending[%0d]", t), 64'(pending[t]), 64'd0);
      end
      report_test("pending bitmap", err0);
   endtask

   task automatic overflow_test();
      int err0;
      int ovf0;
      int t;
      err0 = errors;
      ovf0 = ovf_seen;
      @(negedge clk);
      rf_busy = 1'b1;
      // only the first DEPTH results fit, the last two are lost
      for (int i = 0; i < N_FULL; i++) begin
         send_resp(i % 4, i, load_half_u, 2'(i), $urandom, i < `LR_FIFO_DEPTH);
      end
      stop_resp();
      t = 0;
      while (ovf_seen - ovf0 < 2 && t < 50) begin
         @(negedge clk);
         t++;
      end
      compare_value("full", 64'(full), 64'd1);
      compare_value("cnt", 64'(cnt), 64'(`LR_FIFO_DEPTH));
      rf_busy = 1'b0;
      drain_fifo();
      compare_value("overflow pulses", 64'(ovf_seen - ovf0), 64'd2);
      report_test("overflow", err0);
   endtask

   task automatic rollback_test();
      int          err0;
      logic [31:0] want2;
      err0  = errors;
      want2 = '0;
      @(negedge clk);
      rf_busy = 1'b1;
      for (int i = 0; i < 4; i++) begin
         send_resp(1, 3 + 4 * i, load_byte_u, 2'(i), $urandom, 1'b0);   // squashed later
         send_resp(2, 4 + 4 * i, load_byte, 2'(i), $urandom, 1'b1);
         want2[4 + 4 * i] = 1'b1;
      end
      stop_resp();
      wait_count(N_ROLL);
      @(negedge clk);
      rollback = 4'b0010;     // thread 1 only
      @(negedge clk);
      rollback = '0;
      compare_value("pending[1]", 64'(pending[1]), 64'd0);
      compare_value("pending[2]", 64'(pending[2]), 64'(want2));
      rf_busy = 1'b0;
      drain_fifo();
      // thread 1 registers must hold whatever they had before
      for (int i = 0; i < 4; i++) read_back(1, 3 + 4 * i);
      report_test("rollback", err0);
   endtask

   // ==========================================================
   // main sequence
   // ==========================================================
   initial begin
      void'($urandom(32'hf669));
      rst        = 1'b1;
      resp_valid = 1'b0;
      resp       = '0;
      rollback   = '0;
      rf_busy    = 1'b0;
      rd_thread  = '0;
      rd_reg     = '0;
      for (int t = 0; t < `LR_NTHREADS; t++) begin
         for (int r = 0; r < `LR_NREGS; r++) exp_rf[t][r] = '0;   // unwritten reads zero
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      compare_value("empty", 64'(empty), 64'd1);
      compare_value("cnt", 64'(cnt), 64'd0);
      compare_value("full", 64'(full), 64'd0);
      extension_test();
      burst_order_test();
      pending_map_test();
      overflow_test();
      rollback_test();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* load_return.f */
+incdir+source
source/load_return_pkg.sv
source/load_capture.sv
source/mem_resp_fifo.sv
source/reg_writeback.sv
source/load_return_top.sv
tests/load_return_tb.sv

/* Makefile */
# Verilator flow for the load-return path
TOP = load_return_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall +incdir+source --top-module load_return_top \
		source/load_return_pkg.sv source/load_capture.sv source/mem_resp_fifo.sv \
		source/reg_writeback.sv source/load_return_top.sv

# the run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f load_return.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
